// File: verilog/mmioPkg.sv
package mmioPkg;

	localparam int addrWidth = 13;         // Processor word address
	localparam int coprocBit = 12;         // Set selects coprocessor space
	localparam int memAddrWidth = 12;      // Data memory word index
	localparam int fieldWidth = 5;         // Unit and register fields
	localparam int unitLsb = 7;            // Unit field in bits 11:7
	localparam int regLsb = 2;             // Register field in bits 6:2

	typedef logic [31:0] word_t;
	typedef logic signed [15:0] coord_t;   // Screen coordinate or velocity
	typedef logic [memAddrWidth-1:0] memAddr_t;
	typedef logic [31:0] unitSel_t;        // One bit per unit slot
	typedef logic [31:0] regSel_t;         // One bit per register slot

	localparam int unitPhys1 = 0;
	localparam int unitPhys2 = 1;
	localparam int unitSprite1 = 8;
	localparam int unitSprite2 = 9;
	localparam int unitStage = 10;
	localparam int unitCollision = 12;

	localparam int regGravity = 0;         // Physics registers
	localparam int regStartPos = 1;
	localparam int regControl = 2;
	localparam int regPos = 0;             // Sprite registers
	localparam int regSize = 1;

	typedef struct packed {
		coord_t x;                         // Upper half
		coord_t y;                         // Lower half
	} point_t;

	typedef struct packed {
		point_t pos;                       // Word 63:32 to video
		point_t size;                      // Word 31:0
	} sprite_t;

	typedef struct packed {
		point_t gravity;                   // Only y is used
		point_t control;                   // Only x is used
		point_t startPos;
		logic loadStart;                   // One cycle after startPos write
	} physCfg_t;

	typedef struct packed {
		logic [addrWidth-1:0] address;
		word_t writeData;
		logic writeEnable;
	} busReq_t;

	typedef struct packed {
		logic [28:0] pad;                  // Always zero
		logic p1p2;
		logic p2Stage;
		logic p1Stage;                     // Bit 0 of the read word
	} collide_t;

endpackage

// File: verilog/mmioDecode.sv
module mmioDecode import mmioPkg::*; #(
	parameter int memDepth = 4096
) (
	input busReq_t bus,
	output logic memWrite,
	output memAddr_t memAddr,
	output logic coprocAccess,
	output logic coprocWrite,
	output unitSel_t unitSel,
	output regSel_t regSel
);

	logic [fieldWidth-1:0] unitField;
	logic [fieldWidth-1:0] regField;
	logic [memAddrWidth-1:0] wordIndex;

	assign unitField = bus.address[unitLsb +: fieldWidth];    // Bits 11:7
	assign regField = bus.address[regLsb +: fieldWidth];      // Bits 6:2
	assign wordIndex = bus.address[memAddrWidth-1:0];

	// Bit 12 picks the space
	assign coprocAccess = bus.address[coprocBit];
	assign memWrite = bus.writeEnable & ~coprocAccess;
	assign coprocWrite = bus.writeEnable & coprocAccess;

	// Small memories alias
	assign memAddr = memAddr_t'(wordIndex % memDepth);

	always_comb begin
		unitSel = '0;
		regSel = '0;
		if (coprocAccess) begin                 // Zero outside coprocessor space
			unitSel = unitSel_t'(1) << unitField;
			regSel = regSel_t'(1) << regField;
		end
	end

endmodule

// File: verilog/coprocRegisters.sv
module coprocRegisters import mmioPkg::*; (
	input logic reset,
	input logic clear,
	input word_t writeData,
	input unitSel_t unitSel,
	input regSel_t regSel,
	input logic coprocWrite,
	output physCfg_t cfgP1,
	output physCfg_t cfgP2,
	output sprite_t spriteP1,
	output sprite_t spriteP2,
	output sprite_t spriteStage
);

	unitSel_t unitWrite;

	// Per unit write strobes
	assign unitWrite = coprocWrite ? unitSel : '0;

	// Next state of one physics register group
	function automatic physCfg_t nextCfg(physCfg_t cur, logic wr, regSel_t sel, word_t data);
		physCfg_t nxt;
		nxt = cur;
		nxt.loadStart = wr & sel[regStartPos];      // Single cycle pulse
		if (wr && sel[regGravity])
			nxt.gravity = data;
		if (wr && sel[regStartPos])
			nxt.startPos = data;
		if (wr && sel[regControl])
			nxt.control = data;
		return nxt;
	endfunction

	// Next state of one sprite pair
	function automatic sprite_t nextSprite(sprite_t cur, logic wr, regSel_t sel, word_t data);
		sprite_t nxt;
		nxt = cur;
		if (wr && sel[regPos])
			nxt.pos = data;
		if (wr && sel[regSize])
			nxt.size = data;
		return nxt;
	endfunction

	always_ff @(posedge reset) begin
		if (clear) begin
			cfgP1 <= '0;
			cfgP2 <= '0;
			spriteP1 <= '0;
			spriteP2 <= '0;
			spriteStage <= '0;
		end else begin
			cfgP1 <= nextCfg(cfgP1, unitWrite[unitPhys1], regSel, writeData);
			cfgP2 <= nextCfg(cfgP2, unitWrite[unitPhys2], regSel, writeData);
			spriteP1 <= nextSprite(spriteP1, unitWrite[unitSprite1], regSel, writeData);
			spriteP2 <= nextSprite(spriteP2, unitWrite[unitSprite2], regSel, writeData);
			spriteStage <= nextSprite(spriteStage, unitWrite[unitStage], regSel, writeData);
		end
	end

endmodule

// File: verilog/physicsUnit.sv
module physicsUnit import mmioPkg::*; (
	input logic reset,
	input logic clear,
	input physCfg_t cfg,
	input logic frameTick,
	input logic landed,
	output point_t pos
);

	coord_t vel;                        // Vertical velocity, positive is down
	coord_t velNext;
	coord_t xNext;
	logic resting;

	assign velNext = vel + cfg.gravity.y;       // Wraps at 16 bits
	assign xNext = pos.x + cfg.control.x;       // Signed horizontal step
	assign resting = landed && (vel >= 0);      // On the stage and not rising

	always_ff @(posedge reset) begin
		if (clear) begin
			pos <= '0;
			vel <= '0;
		end else if (cfg.loadStart) begin      // Respawn wins over a frame step
			pos <= cfg.startPos;
			vel <= '0;
		end else if (frameTick) begin
			pos.x <= xNext;                     // Control works on the ground too
			if (resting) begin
				vel <= '0;                       // y holds
			end else begin
				vel <= velNext;
				pos.y <= pos.y + velNext;        // Uses the updated velocity
			end
		end
	end

endmodule

// File: verilog/collisionUnit.sv
module collisionUnit import mmioPkg::*; (
	input point_t posP1,
	input point_t posP2,
	input point_t sizeP1,
	input point_t sizeP2,
	input sprite_t stage,
	output collide_t flags
);

	// One axis, end exclusive, unsigned, with a carry bit so ends never wrap
	function automatic logic spanOverlap(logic [15:0] aLo, logic [15:0] aLen,
		logic [15:0] bLo, logic [15:0] bLen);
		logic [16:0] aHi;
		logic [16:0] bHi;
		aHi = {1'b0, aLo} + {1'b0, aLen};
		bHi = {1'b0, bLo} + {1'b0, bLen};
		return ({1'b0, aLo} < bHi) && ({1'b0, bLo} < aHi);
	endfunction

	// Both axes must overlap
	function automatic logic boxOverlap(point_t aPos, point_t aSize, point_t bPos,
		point_t bSize);
		logic xHit;
		logic yHit;
		xHit = spanOverlap(aPos.x, aSize.x, bPos.x, bSize.x);
		yHit = spanOverlap(aPos.y, aSize.y, bPos.y, bSize.y);
		return xHit && yHit;
	endfunction

	always_comb begin
		flags = '0;                                                        // Pad stays zero
		flags.p1Stage = boxOverlap(posP1, sizeP1, stage.pos, stage.size);
		flags.p2Stage = boxOverlap(posP2, sizeP2, stage.pos, stage.size);
		flags.p1p2 = boxOverlap(posP1, sizeP1, posP2, sizeP2);             // Players touch
	end

endmodule

// File: verilog/dataMemory.sv
module dataMemory import mmioPkg::*; #(
	parameter int memDepth = 4096
) (
	input logic reset,
	input memAddr_t memAddr,
	input word_t writeData,
	input logic memWrite,
	output word_t memData
);

	word_t mem [memDepth];              // No clear on contents

	always_ff @(posedge reset) begin
		if (memWrite)
			mem[memAddr] <= writeData;
		memData <= mem[memAddr];         // Old word on a same-cycle write
	end

endmodule

// File: verilog/mmioReadback.sv
module mmioReadback import mmioPkg::*; (
	input logic reset,
	input logic clear,
	input logic coprocAccess,
	input unitSel_t unitSel,
	input point_t posP1,
	input point_t posP2,
	input collide_t flags,
	input word_t memData,
	output word_t readData
);

	word_t coprocSrc;
	word_t coprocQ;                     // Registered coprocessor word
	logic coprocReadQ;                  // Last address was in coprocessor space
	logic memReadQ;                     // Last address was in memory space

	// Unit slot picks the source, register field ignored
	always_comb begin
		if (unitSel[unitPhys1])
			coprocSrc = posP1;
		else if (unitSel[unitPhys2])
			coprocSrc = posP2;
		else if (unitSel[unitCollision])
			coprocSrc = word_t'(flags);       // Flags in bits 2:0
		else
			coprocSrc = '0;                    // Sprites and empty slots
	end

	always_ff @(posedge reset) begin
		if (clear) begin
			coprocQ <= '0;
			coprocReadQ <= 1'b0;
			memReadQ <= 1'b0;
		end else begin
			coprocQ <= coprocSrc;
			coprocReadQ <= coprocAccess;
			memReadQ <= ~coprocAccess;         // Lines up with memory read latency
		end
	end

	assign readData = coprocReadQ ? coprocQ : (memReadQ ? memData : '0);

endmodule

// File: verilog/mmio.sv
module mmio import mmioPkg::*; #(
	parameter int memDepth = 4096
) (
	input logic reset,
	input logic clear,
	input busReq_t bus,
	input logic frameTick,
	output word_t readData,
	output sprite_t spriteP1,
	output sprite_t spriteP2,
	output sprite_t spriteStage,
	output point_t posP1,
	output point_t posP2
);

	logic memWrite;
	memAddr_t memAddr;
	logic coprocAccess;
	logic coprocWrite;
	unitSel_t unitSel;
	regSel_t regSel;
	physCfg_t cfgP1;
	physCfg_t cfgP2;
	collide_t flags;
	word_t memData;

	mmioDecode #(.memDepth(memDepth)) i_decode (
		.bus(bus), .memWrite(memWrite), .memAddr(memAddr), .coprocAccess(coprocAccess),
		.coprocWrite(coprocWrite), .unitSel(unitSel), .regSel(regSel)
	);

	coprocRegisters i_regs (
		.reset(reset), .clear(clear), .writeData(bus.writeData), .unitSel(unitSel),
		.regSel(regSel), .coprocWrite(coprocWrite), .cfgP1(cfgP1), .cfgP2(cfgP2),
		.spriteP1(spriteP1), .spriteP2(spriteP2), .spriteStage(spriteStage)
	);

	physicsUnit i_physP1 (                  // Lands on its own stage flag
		.reset(reset), .clear(clear), .cfg(cfgP1), .frameTick(frameTick),
		.landed(flags.p1Stage), .pos(posP1)
	);

	physicsUnit i_physP2 (
		.reset(reset), .clear(clear), .cfg(cfgP2), .frameTick(frameTick),
		.landed(flags.p2Stage), .pos(posP2)
	);

	collisionUnit i_collision (             // Player boxes sized by sprite registers
		.posP1(posP1), .posP2(posP2), .sizeP1(spriteP1.size), .sizeP2(spriteP2.size),
		.stage(spriteStage), .flags(flags)
	);

	dataMemory #(.memDepth(memDepth)) i_mem (
		.reset(reset), .memAddr(memAddr), .writeData(bus.writeData),
		.memWrite(memWrite), .memData(memData)
	);

	mmioReadback i_readback (
		.reset(reset), .clear(clear), .coprocAccess(coprocAccess), .unitSel(unitSel),
		.posP1(posP1), .posP2(posP2), .flags(flags), .memData(memData),
		.readData(readData)
	);

endmodule

// File: verification/mmio_chk.sv
module mmio_chk import mmioPkg::*; (
	input logic reset,
	input logic clear,
	input word_t readData,
	input logic memWrite,
	input logic coprocAccess,
	input unitSel_t unitSel,
	input sprite_t spriteP1,
	input sprite_t spriteP2,
	input sprite_t spriteStage
);

	logic otherUnit;                    // Coprocessor slot without a read source

	assign otherUnit = coprocAccess && !unitSel[unitPhys1] && !unitSel[unitPhys2] &&
		!unitSel[unitCollision];

	// Read-back register cleared with everything else
	readZeroAfterClear: assert property (@(posedge reset) clear |=> readData == '0)
		else $error("readData not zero after clear");

	// Memory space writes never reach the sprite registers
	memWriteKeepsSprites: assert property (@(posedge reset)
		memWrite && !clear |=>
		$stable(spriteP1) && $stable(spriteP2) && $stable(spriteStage))
		else $error("memory write changed a sprite register");

	unusedSlotReadsZero: assert property (@(posedge reset)
		otherUnit && !clear |=> readData == '0)
		else $error("sprite or unused unit slot did not read as zero");

endmodule

bind mmio mmio_chk i_chk (
	.reset(reset),
	.clear(clear),
	.readData(readData),
	.memWrite(memWrite),
	.coprocAccess(coprocAccess),
	.unitSel(unitSel),
	.spriteP1(spriteP1),
	.spriteP2(spriteP2),
	.spriteStage(spriteStage)
);

// File: verification/mmioMonitor.sv
module mmioMonitor import mmioPkg::*; #(
	parameter int memDepth = 4096
) (
	input logic reset,
	input logic clear,
	input busReq_t bus,
	input word_t readData,
	input sprite_t spriteP1,
	input sprite_t spriteP2,
	input sprite_t spriteStage,
	input point_t posP1,
	input point_t posP2,
	input point_t expP1,
	input point_t expP2,
	input sprite_t expSpriteP1,
	input sprite_t expSpriteP2,
	input sprite_t expSpriteStage,
	input collide_t expFlags,
	output int errorCount
);

	word_t shadowMem [int];             // Only words written so far
	logic armed;                        // Outputs defined after the first clear edge
	logic readPending;                  // A read result is due this edge
	word_t readExp;

	initial begin
		errorCount = 0;
		armed = 1'b0;
		readPending = 1'b0;
		readExp = '0;
	end

	task automatic compare(string name, logic [63:0] expVal, logic [63:0] actVal);
		if (actVal !== expVal) begin
			errorCount++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, expVal,
				actVal);
		end
	endtask

	// Ports hold the values from the previous edge here
	always @(posedge reset) begin : compareOutputs
		int index;
		int unit;
		index = int'(bus.address[memAddrWidth-1:0]) % memDepth;
		unit = int'(bus.address[unitLsb +: fieldWidth]);
		if (armed) begin
			compare("spriteP1", 64'(expSpriteP1), 64'(spriteP1));
			compare("spriteP2", 64'(expSpriteP2), 64'(spriteP2));
			compare("spriteStage", 64'(expSpriteStage), 64'(spriteStage));
			compare("posP1", 64'(expP1), 64'(posP1));
			compare("posP2", 64'(expP2), 64'(posP2));
			if (readPending)
				compare("readData", 64'(readExp), 64'(readData));
		end
		readPending = 1'b0;
		if (!clear && !bus.writeEnable) begin
			readPending = 1'b1;
			if (bus.address[coprocBit]) begin
				case (unit)
					unitPhys1: readExp = expP1;    // Any register number
					unitPhys2: readExp = expP2;
					unitCollision: readExp = word_t'(expFlags);
					default: readExp = '0;
				endcase
			end else if (shadowMem.exists(index)) begin
				readExp = shadowMem[index];
			end else begin
				readPending = 1'b0;            // Never written, contents unknown
			end
		end
		if (bus.writeEnable && !bus.address[coprocBit])
			shadowMem[index] = bus.writeData;  // Memory ignores clear
		if (clear)
			armed = 1'b1;
	end

endmodule

// File: verification/mmioTb.sv
module mmioTb import mmioPkg::*; ();

	localparam int memDepth = 4096;
	localparam int memOps = 60;                // Random memory accesses
	localparam int driftSteps = 60;            // Free fall far from the stage
	localparam int landSteps = 40;             // Fall onto the stage
	localparam int fixedOps = 60;              // Directed register accesses
	localparam int plannedOps = memOps + driftSteps + landSteps + fixedOps;
	localparam int watchdogTime = (plannedOps * 20 + 3) * 8;

	typedef struct packed {
		point_t pos;
		coord_t vel;
	} body_t;

	logic reset;                               // Clock
	logic clear;
	logic frameTick;
	busReq_t bus;
	word_t readData;
	sprite_t spriteP1;
	sprite_t spriteP2;
	sprite_t spriteStage;
	point_t posP1;
	point_t posP2;
	int errorCount;

	// Reference state
	point_t expPos [2];
	coord_t expVel [2];
	word_t gravity [2];
	word_t control [2];
	point_t startPos [2];
	logic loadQ [2];                           // Start position pending
	sprite_t expSprite [3];                    // P1, P2, stage
	collide_t expFlags;

	mmio #(.memDepth(memDepth)) i_dut (
		.reset(reset), .clear(clear), .bus(bus), .frameTick(frameTick),
		.readData(readData), .spriteP1(spriteP1), .spriteP2(spriteP2),
		.spriteStage(spriteStage), .posP1(posP1), .posP2(posP2)
	);

	mmioMonitor #(.memDepth(memDepth)) i_monitor (
		.reset(reset), .clear(clear), .bus(bus), .readData(readData),
		.spriteP1(spriteP1), .spriteP2(spriteP2), .spriteStage(spriteStage),
		.posP1(posP1), .posP2(posP2), .expP1(expPos[0]), .expP2(expPos[1]),
		.expSpriteP1(expSprite[0]), .expSpriteP2(expSprite[1]),
		.expSpriteStage(expSprite[2]), .expFlags(expFlags), .errorCount(errorCount)
	);

	always #4 reset = ~reset;

	// One frame of the physics rule
	function automatic body_t stepPhysics(body_t cur, coord_t gravY, coord_t ctrlX,
		logic landed);
		body_t nxt;
		nxt = cur;
		nxt.pos.x = cur.pos.x + ctrlX;
		if (landed && cur.vel >= 16'sd0) begin
			nxt.vel = '0;                      // Standing, y holds
		end else begin
			nxt.vel = cur.vel + gravY;
			nxt.pos.y = cur.pos.y + nxt.vel;
		end
		return nxt;
	endfunction

	// Boxes as unsigned spans with exclusive ends
	function automatic logic overlap(point_t aPos, point_t aSize, point_t bPos, point_t bSize);
		logic [16:0] aEndX;
		logic [16:0] aEndY;
		logic [16:0] bEndX;
		logic [16:0] bEndY;
		aEndX = {1'b0, aPos.x} + {1'b0, aSize.x};
		aEndY = {1'b0, aPos.y} + {1'b0, aSize.y};
		bEndX = {1'b0, bPos.x} + {1'b0, bSize.x};
		bEndY = {1'b0, bPos.y} + {1'b0, bSize.y};
		return ({1'b0, aPos.x} < bEndX) && ({1'b0, bPos.x} < aEndX) &&
			({1'b0, aPos.y} < bEndY) && ({1'b0, bPos.y} < aEndY);
	endfunction

	always_comb begin
		expFlags = '0;
		expFlags.p1Stage = overlap(expPos[0], expSprite[0].size, expSprite[2].pos,
			expSprite[2].size);
		expFlags.p2Stage = overlap(expPos[1], expSprite[1].size, expSprite[2].pos,
			expSprite[2].size);
		expFlags.p1p2 = overlap(expPos[0], expSprite[0].size, expPos[1], expSprite[1].size);
	end

	// Reference model, follows the driven bus at each edge
	always @(posedge reset) begin : refModel
		int unit;
		int regNum;
		logic coprocWr;
		logic landed;
		body_t body;
		unit = int'(bus.address[unitLsb +: fieldWidth]);
		regNum = int'(bus.address[regLsb +: fieldWidth]);
		coprocWr = bus.writeEnable && bus.address[coprocBit];
		for (int p = 0; p < 2; p++) begin
			landed = (p == 0) ? expFlags.p1Stage : expFlags.p2Stage;
			loadQ[p] <= 1'b0;
			if (clear) begin
				{expPos[p], expVel[p], gravity[p], control[p], startPos[p]} <= '0;
			end else begin
				if (coprocWr && unit == unitPhys1 + p) begin
					if (regNum == regGravity)
						gravity[p] <= bus.writeData;
					if (regNum == regControl)
						control[p] <= bus.writeData;
					if (regNum == regStartPos) begin
						startPos[p] <= bus.writeData;
						loadQ[p] <= 1'b1;      // Load on the next edge
					end
				end
				if (loadQ[p]) begin
					expPos[p] <= startPos[p];
					expVel[p] <= '0;
				end else if (frameTick) begin
					body = stepPhysics({expPos[p], expVel[p]}, gravity[p][15:0],
						control[p][31:16], landed);
					expPos[p] <= body.pos;
					expVel[p] <= body.vel;
				end
			end
		end
		for (int s = 0; s < 3; s++) begin
			if (clear)
				expSprite[s] <= '0;
			else if (coprocWr && unit == unitSprite1 + s && regNum == regPos)
				expSprite[s].pos <= bus.writeData;
			else if (coprocWr && unit == unitSprite1 + s && regNum == regSize)
				expSprite[s].size <= bus.writeData;
		end
	end

	function automatic logic [12:0] coprocAddr(int unit, int regNum);
		return {1'b1, 5'(unit), 5'(regNum), 2'b00};
	endfunction

	task automatic busCycle(logic [12:0] addr, word_t data, logic we, logic tick);
		@(negedge reset);
		bus.address = addr;
		bus.writeData = data;
		bus.writeEnable = we;
		frameTick = tick;
	endtask

	task automatic writeCoproc(int unit, int regNum, word_t data);
		busCycle(coprocAddr(unit, regNum), data, 1'b1, 1'b0);
	endtask

	task automatic readCoproc(int unit, int regNum);
		busCycle(coprocAddr(unit, regNum), '0, 1'b0, 1'b0);
	endtask

	task automatic idleCycle();
		busCycle(13'd0, '0, 1'b0, 1'b0);       // Memory read of word 0
	endtask

	initial begin : watchdog
		#(watchdogTime);
		$display("Timeout: stimulus did not finish within %0d time units", watchdogTime);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : stimulus
		void'($urandom(32'h35b8));
		reset = 1'b0;
		clear = 1'b1;
		bus = '0;
		frameTick = 1'b0;
		repeat (3) @(negedge reset);
		clear = 1'b0;
		repeat (memOps)                         // Small window so reads hit written words
			busCycle(13'($urandom % 64), $urandom, 1'($urandom % 2), 1'b0);
		writeCoproc(unitSprite1, regPos, {16'd20, 16'd30});
		writeCoproc(unitSprite1, regSize, {16'd8, 16'd8});
		writeCoproc(unitSprite2, regPos, {16'd40, 16'd50});
		writeCoproc(unitSprite2, regSize, {16'd8, 16'd8});
		writeCoproc(unitStage, regPos, {16'h7000, 16'h7000});   // Far from the players
		writeCoproc(unitStage, regSize, {16'h0010, 16'h0010});
		writeCoproc(unitStage, 5, 32'hdead_beef);               // Undefined register
		readCoproc(unitSprite1, regPos);
		readCoproc(unitStage, regSize);
		readCoproc(3, 0);
		readCoproc(31, 7);
		writeCoproc(unitPhys1, regStartPos, {16'd10, 16'd20});
		writeCoproc(unitPhys2, regStartPos, {16'd60, 16'd5});
		readCoproc(unitPhys1, 9);
		readCoproc(unitPhys2, 17);
		for (int p = 0; p < 2; p++) begin
			writeCoproc(unitPhys1 + p, regGravity, {16'd0, 16'(1 + $urandom % 3)});
			writeCoproc(unitPhys1 + p, regControl, {16'(($urandom % 5) - 2), 16'd0});
		end
		repeat (driftSteps)
			busCycle(coprocAddr($urandom % 2, $urandom % 32), '0, 1'b0, 1'($urandom % 2));
		writeCoproc(unitStage, regPos, {16'd0, 16'd100});
		writeCoproc(unitStage, regSize, {16'd200, 16'd20});
		writeCoproc(unitPhys1, regGravity, {16'd0, 16'd2});
		writeCoproc(unitPhys2, regGravity, {16'd0, 16'd2});
		writeCoproc(unitPhys1, regControl, {16'd1, 16'd0});
		writeCoproc(unitPhys2, regControl, {16'hffff, 16'd0});  // Moves left
		writeCoproc(unitPhys1, regStartPos, {16'd10, 16'd40});
		writeCoproc(unitPhys2, regStartPos, {16'd150, 16'd0});
		repeat (landSteps)
			busCycle(coprocAddr(unitCollision, 0), '0, 1'b0, 1'b1);
		writeCoproc(unitPhys1, regStartPos, {16'd100, 16'd10});
		writeCoproc(unitPhys2, regStartPos, {16'd104, 16'd12});  // Boxes overlap
		readCoproc(unitCollision, 0);
		readCoproc(unitCollision, 0);
		busCycle(13'd100, 32'hc0de_0100, 1'b1, 1'b1);
		clear = 1'b1;                           // Memory write still lands
		repeat (2) idleCycle();
		clear = 1'b0;
		busCycle(13'd100, '0, 1'b0, 1'b0);
		readCoproc(unitPhys1, 0);
		readCoproc(unitCollision, 0);
		readCoproc(unitPhys2, 3);
		repeat (3) idleCycle();
		@(negedge reset);
		$display("Checks finished with %0d errors", errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: list.f
verilog/mmioPkg.sv
verilog/mmioDecode.sv
verilog/coprocRegisters.sv
verilog/physicsUnit.sv
verilog/collisionUnit.sv
verilog/dataMemory.sv
verilog/mmioReadback.sv
verilog/mmio.sv
verification/mmio_chk.sv
verification/mmioMonitor.sv
verification/mmioTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mmioTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= TEST OK
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
